//--- source/abr_params_pkg.sv
package abr_params_pkg;

    // ----------------------------------------
    // Memory side
    // ----------------------------------------

    // Word address into the coefficient memory and into the register window
    localparam int ABR_MEM_ADDR_WIDTH = 10;

    typedef logic [ABR_MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // ----------------------------------------
    // Register port
    // ----------------------------------------

    // One register write carries a full dword
    localparam int REG_DWORD_WIDTH = 32;

    typedef logic [REG_DWORD_WIDTH-1:0] reg_dword_t;

endpackage

//--- source/makehint_defines_pkg.sv
package makehint_defines_pkg;

    // ----------------------------------------
    // Coefficient storage types
    // ----------------------------------------

    // Stored coefficient width, the top bit is always zero for reduced values
    localparam int REG_SIZE = 24;

    typedef logic [REG_SIZE-1:0] coeff_t;

    // One memory word holds four coefficients, lane 0 in the low bits
    typedef coeff_t [3:0] coeff4_t;

    // One z-differs flag per coefficient lane
    typedef logic [3:0] zbits_t;

    // Position of a coefficient inside its 256-entry polynomial
    typedef logic [7:0] hint_index_t;

    // ----------------------------------------
    // Modulus constants
    // ----------------------------------------

    localparam coeff_t DILITHIUM_Q = 24'd8380417;
    localparam coeff_t GAMMA2 = (DILITHIUM_Q - 24'd1) / 24'd32;

    // Read sequencer states of the control block
    typedef enum logic [2:0] {
        MH_IDLE,
        MH_RD_MEM,
        MH_WAIT1,
        MH_WAIT2,
        MH_FLUSH_SBUF,
        MH_RD_IBUF_LOW,
        MH_RD_IBUF_MID,
        MH_RD_IBUF_HIGH
    } mh_read_state_e;

endpackage

//--- source/hintgen.sv
module hintgen
    import makehint_defines_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize,
    input  logic   enable,
    input  coeff_t r,
    input  logic   z_neq_z,
    output logic   h
);

    // Upper edge of the hint band
    localparam coeff_t HINT_HI = DILITHIUM_Q - GAMMA2;

    logic in_band;
    logic on_edge;
    logic hint_nxt;

    // Strictly inside the band always gives a hint
    assign in_band = (r > GAMMA2) && (r < HINT_HI);

    // Exactly on the upper edge the z flag decides
    assign on_edge = (r == HINT_HI) && z_neq_z;

    // Idle lanes never report a hint
    assign hint_nxt = enable && (in_band || on_edge);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h <= 1'b0;
        end else if (zeroize) begin
            h <= 1'b0;
        end else begin
            h <= hint_nxt;
        end
    end

    // Memory contents must already be reduced mod q when a lane is fed
    r_reduced_a: assert property (@(posedge clk) disable iff (!reset_n)
        enable |-> (r < DILITHIUM_Q));

endmodule

//--- source/makehint_sample_buffer.sv
module makehint_sample_buffer
    import abr_params_pkg::*;
    import makehint_defines_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              flush,
    input  logic [3:0]        data_valid_i,
    input  hint_index_t [3:0] data_i,
    output logic              data_valid_o,
    output reg_dword_t        data_o
);

    // Byte store, oldest byte in slot 0, unused slots kept at zero
    hint_index_t [7:0] store;
    logic [3:0]        fill;

    // Store with this cycle's bytes appended
    hint_index_t [7:0] merged;
    logic [3:0]        merged_fill;

    // ----------------------------------------
    // Append incoming bytes in lane order
    // ----------------------------------------

    always_comb begin
        merged = store;
        merged_fill = fill;
        for (int i = 0; i < 4; i++) begin
            if (data_valid_i[i]) begin
                // Fill stays below 8 here, so three bits select the slot
                merged[merged_fill[2:0]] = data_i[i];
                merged_fill = merged_fill + 4'd1;
            end
        end
    end

    // A dword leaves as soon as four bytes are available
    // On flush whatever is left goes out, zero padded by the empty slots
    assign data_valid_o = flush || (merged_fill >= 4'd4);
    assign data_o = reg_dword_t'(merged[3:0]);

    // ----------------------------------------
    // Store update
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            store <= '0;
            fill <= '0;
        end else if (flush) begin
            store <= '0;
            fill <= '0;
        end else if (merged_fill >= 4'd4) begin
            // Drop the four bytes just emitted and move the rest down
            store <= {32'h0, merged[7:4]};
            fill <= merged_fill - 4'd4;
        end else begin
            store <= merged;
            fill <= merged_fill;
        end
    end

    // Leftover plus one full lane group must fit the eight slots
    fill_limit_a: assert property (@(posedge clk) disable iff (!reset_n)
        merged_fill <= 4'd8);

endmodule

//--- source/makehint_coeff_mem.sv
module makehint_coeff_mem
    import abr_params_pkg::*;
    import makehint_defines_pkg::*;
(
    input  logic      clk,
    input  logic      load_en,
    input  mem_addr_t load_addr,
    input  coeff4_t   load_r,
    input  zbits_t    load_z,
    input  logic      mem_rd_en,
    input  mem_addr_t mem_rd_addr,
    output coeff4_t   mem_r,
    output zbits_t    mem_z
);

    localparam int DEPTH = 2 ** ABR_MEM_ADDR_WIDTH;

    // r and z share one word address
    coeff4_t r_store [DEPTH];
    zbits_t  z_store [DEPTH];

    // Load port, one full word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            r_store[load_addr] <= load_r;
            z_store[load_addr] <= load_z;
        end
    end

    // Registered read, data shows up the cycle after the request
    always_ff @(posedge clk) begin
        if (mem_rd_en) begin
            mem_r <= r_store[mem_rd_addr];
            mem_z <= z_store[mem_rd_addr];
        end
    end

    // Loading is only legal while the control block sits idle
    no_load_during_read_a: assert property (@(posedge clk) load_en |-> !mem_rd_en);

endmodule

//--- source/makehint.sv
module makehint
    import abr_params_pkg::*;
    import makehint_defines_pkg::*;
#(
    parameter int DILITHIUM_K = 8,
    parameter int OMEGA = 75
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize,
    input  logic              makehint_enable,
    input  mem_addr_t         mem_base_addr,
    input  mem_addr_t         dest_base_addr,
    input  logic [3:0]        hint,
    input  logic              sample_valid,
    input  reg_dword_t        sample_data,
    output logic              mem_rd_en,
    output mem_addr_t         mem_rd_addr,
    output logic              hint_enable,
    output hint_index_t [3:0] index,
    output logic              flush_buffer,
    output logic              invalid_h,
    output logic              makehint_done,
    output logic              reg_wren,
    output mem_addr_t         reg_wr_addr,
    output reg_dword_t        reg_wrdata
);

    // One spare bit so the bound check on the counter means something
    localparam int POLY_W = $clog2(DILITHIUM_K) + 1;

    mh_read_state_e state;
    mh_read_state_e state_nxt;
    logic start;

    mem_addr_t rd_addr;
    logic last_addr_read;
    logic [POLY_W-1:0] poly_count;
    logic poly_last;
    logic poly_end;
    logic rd_en_d2;
    hint_index_t index_count;

    logic [7:0] hint_sum;
    logic [7:0] hint_sum_nxt;
    logic [DILITHIUM_K-1:0][7:0] max_index_buffer;

    logic ibuf_rd;
    reg_dword_t count_data;
    mem_addr_t wr_offset;

    // ----------------------------------------
    // Read sequencer
    // ----------------------------------------

    assign start = (state == MH_IDLE) && makehint_enable;

    // 64 words per polynomial, the address runs on across polynomials
    assign last_addr_read = (rd_addr[5:0] == 6'h3f);
    assign poly_last = (poly_count == POLY_W'(DILITHIUM_K - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= MH_IDLE;
        end else if (zeroize) begin
            state <= MH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            MH_IDLE: begin
                if (start) begin
                    state_nxt = MH_RD_MEM;
                end
            end
            MH_RD_MEM: begin
                if (last_addr_read) begin
                    state_nxt = MH_WAIT1;
                end
            end
            // Two idle cycles let the last hints of the polynomial drain
            MH_WAIT1: state_nxt = MH_WAIT2;
            MH_WAIT2: state_nxt = poly_last ? MH_FLUSH_SBUF : MH_RD_MEM;
            MH_FLUSH_SBUF: state_nxt = MH_RD_IBUF_LOW;
            MH_RD_IBUF_LOW: state_nxt = MH_RD_IBUF_MID;
            MH_RD_IBUF_MID: state_nxt = MH_RD_IBUF_HIGH;
            default: state_nxt = MH_IDLE;
        endcase
    end

    assign makehint_done = (state == MH_IDLE);
    assign mem_rd_en = (state == MH_RD_MEM);
    assign mem_rd_addr = mem_base_addr + rd_addr;

    // All hints of a polynomial have reached the lanes by WAIT2
    assign poly_end = (state == MH_WAIT2);

    // ----------------------------------------
    // Counters
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
            poly_count <= '0;
            index_count <= '0;
        end else if (zeroize || makehint_done) begin
            rd_addr <= '0;
            poly_count <= '0;
            index_count <= '0;
        end else begin
            if (mem_rd_en) begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (poly_end && !poly_last) begin
                poly_count <= poly_count + 1'b1;
            end
            // Wraps to zero after 256 coefficients, ready for the next polynomial
            if (rd_en_d2) begin
                index_count <= index_count + 8'd4;
            end
        end
    end

    // Memory latency plus the lane register put each hint two cycles after its read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_enable <= 1'b0;
            rd_en_d2 <= 1'b0;
        end else if (zeroize) begin
            hint_enable <= 1'b0;
            rd_en_d2 <= 1'b0;
        end else begin
            hint_enable <= mem_rd_en;
            rd_en_d2 <= hint_enable;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            index[i] = index_count + hint_index_t'(i);
        end
    end

    // ----------------------------------------
    // Hint sum and count buffer
    // ----------------------------------------

    assign hint_sum_nxt = hint_sum + 8'($countones(hint));

    // The running sum is never cleared between polynomials
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_sum <= '0;
            max_index_buffer <= '0;
        end else if (zeroize || makehint_done) begin
            hint_sum <= '0;
            max_index_buffer <= '0;
        end else begin
            hint_sum <= hint_sum_nxt;
            // Shift in the sum including this cycle's hints, polynomial 0 ends in slot 0
            if (poly_end) begin
                max_index_buffer <= {hint_sum_nxt, max_index_buffer[DILITHIUM_K-1:1]};
            end
        end
    end

    // Sticky until the next start or a zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid_h <= 1'b0;
        end else if (zeroize || start) begin
            invalid_h <= 1'b0;
        end else if (hint_sum_nxt > 8'(OMEGA)) begin
            invalid_h <= 1'b1;
        end
    end

    // Count dword layout covers eight polynomials
    always_comb begin
        case (state)
            MH_RD_IBUF_LOW: count_data = {max_index_buffer[0], 24'h0};
            MH_RD_IBUF_MID: count_data = max_index_buffer[4:1];
            MH_RD_IBUF_HIGH: count_data = {8'h0, max_index_buffer[7:5]};
            default: count_data = '0;
        endcase
    end

    // ----------------------------------------
    // Register port
    // ----------------------------------------

    assign ibuf_rd = (state == MH_RD_IBUF_LOW) || (state == MH_RD_IBUF_MID) ||
                     (state == MH_RD_IBUF_HIGH);

    // Zeroize also empties the sample buffer, that flush must not reach the port
    assign flush_buffer = (state == MH_FLUSH_SBUF) || zeroize;
    assign reg_wren = !zeroize && (sample_valid || ibuf_rd);
    assign reg_wrdata = ibuf_rd ? count_data : sample_data;
    assign reg_wr_addr = dest_base_addr + wr_offset;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_offset <= '0;
        end else if (zeroize || makehint_done) begin
            wr_offset <= '0;
        end else if (state == MH_FLUSH_SBUF) begin
            // Flush takes the next index slot, then the counts go to their fixed slots
            wr_offset <= mem_addr_t'(OMEGA / 4);
        end else if (reg_wren) begin
            wr_offset <= wr_offset + 1'b1;
        end
    end

    // Pending sample output must have drained before the sequencer goes idle
    no_write_idle_a: assert property (@(posedge clk) disable iff (!reset_n)
        (state == MH_IDLE) |-> !reg_wren);

    poly_bound_a: assert property (@(posedge clk) disable iff (!reset_n)
        (state != MH_IDLE) |-> (poly_count < POLY_W'(DILITHIUM_K)));

endmodule

//--- source/makehint_top.sv
module makehint_top
    import abr_params_pkg::*;
    import makehint_defines_pkg::*;
#(
    parameter int DILITHIUM_K = 8,
    parameter int OMEGA = 75
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize,
    input  logic       makehint_enable,
    input  mem_addr_t  mem_base_addr,
    input  mem_addr_t  dest_base_addr,
    input  logic       load_en,
    input  mem_addr_t  load_addr,
    input  coeff4_t    load_r,
    input  zbits_t     load_z,
    output logic       invalid_h,
    output logic       makehint_done,
    output logic       reg_wren,
    output mem_addr_t  reg_wr_addr,
    output reg_dword_t reg_wrdata
);

    // Memory read path
    logic      mem_rd_en;
    mem_addr_t mem_rd_addr;
    coeff4_t   mem_r;
    zbits_t    mem_z;

    // Lane and sample buffer path
    logic              hint_enable;
    logic [3:0]        hint;
    hint_index_t [3:0] index;
    logic              flush_buffer;
    logic              sample_valid;
    reg_dword_t        sample_data;

    makehint_coeff_mem makehint_coeff_mem_i (
        .clk         (clk),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_r      (load_r),
        .load_z      (load_z),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_r       (mem_r),
        .mem_z       (mem_z)
    );

    makehint #(
        .DILITHIUM_K (DILITHIUM_K),
        .OMEGA       (OMEGA)
    ) makehint_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .makehint_enable (makehint_enable),
        .mem_base_addr   (mem_base_addr),
        .dest_base_addr  (dest_base_addr),
        .hint            (hint),
        .sample_valid    (sample_valid),
        .sample_data     (sample_data),
        .mem_rd_en       (mem_rd_en),
        .mem_rd_addr     (mem_rd_addr),
        .hint_enable     (hint_enable),
        .index           (index),
        .flush_buffer    (flush_buffer),
        .invalid_h       (invalid_h),
        .makehint_done   (makehint_done),
        .reg_wren        (reg_wren),
        .reg_wr_addr     (reg_wr_addr),
        .reg_wrdata      (reg_wrdata)
    );

    // One hint lane per coefficient of a memory word
    for (genvar i = 0; i < 4; i++) begin : g_lane
        hintgen hintgen_i (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .enable  (hint_enable),
            .r       (mem_r[i]),
            .z_neq_z (mem_z[i]),
            .h       (hint[i])
        );
    end

    makehint_sample_buffer makehint_sample_buffer_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .flush        (flush_buffer),
        .data_valid_i (hint),
        .data_i       (index),
        .data_valid_o (sample_valid),
        .data_o       (sample_data)
    );

endmodule

//--- include/makehint_tb_model.svh
`ifndef MAKEHINT_TB_MODEL_SVH
`define MAKEHINT_TB_MODEL_SVH

// Modulus and band width, worked out here from their definitions
localparam int MODEL_Q = 8380417;
localparam int MODEL_GAMMA2 = (MODEL_Q - 1) / 32;

// ----------------------------------------
// Random source
// ----------------------------------------

// Galois LFSR, one step for every bit handed out
function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[30:0], next_bit()};
    end
    return val;
endfunction

// ----------------------------------------
// Reference model
// ----------------------------------------

// Hint when r lies strictly inside the band, or on its upper edge with z set
function automatic logic expect_hint(input coeff_t r, input logic z);
    int val;
    int upper_edge;
    val = int'(r);
    upper_edge = MODEL_Q - MODEL_GAMMA2;
    if ((val > MODEL_GAMMA2) && (val < upper_edge)) begin
        return 1'b1;
    end
    return (val == upper_edge) && z;
endfunction

// Expected register writes in the order they leave the port
function automatic void build_expected(input mem_addr_t dest);
    hint_index_t idx_q[$];
    logic [7:0] counts [DILITHIUM_K];
    int total;
    reg_dword_t word;
    exp_addr_q.delete();
    exp_data_q.delete();
    total = 0;
    for (int p = 0; p < DILITHIUM_K; p++) begin
        for (int j = 0; j < 256; j++) begin
            if (expect_hint(coef_r[p*256 + j], coef_z[p*256 + j])) begin
                idx_q.push_back(hint_index_t'(j));
                total++;
            end
        end
        // Counts are running totals, one byte each
        counts[p] = 8'(total);
    end
    // Full index dwords, then the flush dword with the leftover bytes
    for (int d = 0; d <= idx_q.size() / 4; d++) begin
        word = '0;
        for (int b = 0; b < 4; b++) begin
            if (4*d + b < idx_q.size()) begin
                word[8*b +: 8] = idx_q[4*d + b];
            end
        end
        exp_addr_q.push_back(dest + mem_addr_t'(d));
        exp_data_q.push_back(word);
    end
    // The three count dwords at their fixed offsets
    word = '0;
    word[31:24] = counts[0];
    exp_addr_q.push_back(dest + mem_addr_t'(OMEGA / 4));
    exp_data_q.push_back(word);
    word = '0;
    for (int b = 0; b < 4; b++) begin
        word[8*b +: 8] = counts[1 + b];
    end
    exp_addr_q.push_back(dest + mem_addr_t'(OMEGA / 4 + 1));
    exp_data_q.push_back(word);
    word = '0;
    for (int b = 0; b < 3; b++) begin
        word[8*b +: 8] = counts[5 + b];
    end
    exp_addr_q.push_back(dest + mem_addr_t'(OMEGA / 4 + 2));
    exp_data_q.push_back(word);
    exp_invalid = (total > OMEGA);
endfunction

// Running hint count at the end of the given number of polynomials
function automatic int count_hints(input int polys);
    int total;
    total = 0;
    for (int j = 0; j < polys * 256; j++) begin
        if (expect_hint(coef_r[j], coef_z[j])) begin
            total++;
        end
    end
    return total;
endfunction

// ----------------------------------------
// Compare tasks
// ----------------------------------------

task automatic check_dword(input string name, input reg_dword_t act, input reg_dword_t exp);
    checks++;
    if (act !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, act, exp);
        errors++;
    end
endtask

task automatic check_addr(input string name, input mem_addr_t act, input mem_addr_t exp);
    checks++;
    if (act !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, act, exp);
        errors++;
    end
endtask

task automatic check_flag(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, act, exp);
        errors++;
    end
endtask

// Walk the logged writes against the expected ones
task automatic compare_writes();
    int n;
    checks++;
    if (wr_addr_q.size() != exp_addr_q.size()) begin
        $display("The DUT made %0d register writes where %0d were expected",
                 wr_addr_q.size(), exp_addr_q.size());
        errors++;
    end
    n = (wr_addr_q.size() < exp_addr_q.size()) ? wr_addr_q.size() : exp_addr_q.size();
    for (int i = 0; i < n; i++) begin
        check_addr($sformatf("reg_wr_addr (write %0d)", i), wr_addr_q[i], exp_addr_q[i]);
        check_dword($sformatf("reg_wrdata (write %0d)", i), wr_data_q[i], exp_data_q[i]);
    end
endtask

`endif

//--- testbench/makehint_tb.sv
module makehint_tb
    import abr_params_pkg::*;
    import makehint_defines_pkg::*;
();

    localparam int DILITHIUM_K = 8;
    localparam int OMEGA = 75;
    localparam int NUM_TESTS = 5;
    localparam int RUN_CYCLES = DILITHIUM_K * 66 + 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (DILITHIUM_K * 66 + 64 * DILITHIUM_K + 50);

    // Polynomials reloaded with dense hints before the zeroize of test 5
    localparam int ZEROIZE_POLYS = 5;

    // Kinds of coefficient fill
    localparam int KIND_SPARSE = 0;
    localparam int KIND_DENSE = 1;
    localparam int KIND_BOUNDARY = 2;

    logic       clk;
    logic       reset_n;
    logic       zeroize;
    logic       makehint_enable;
    mem_addr_t  mem_base_addr;
    mem_addr_t  dest_base_addr;
    logic       load_en;
    mem_addr_t  load_addr;
    coeff4_t    load_r;
    zbits_t     load_z;
    logic       invalid_h;
    logic       makehint_done;
    logic       reg_wren;
    mem_addr_t  reg_wr_addr;
    reg_dword_t reg_wrdata;

    // Copy of every coefficient loaded, indexed by poly*256 + position
    coeff_t coef_r [DILITHIUM_K*256];
    logic   coef_z [DILITHIUM_K*256];

    // Logged and expected register writes
    mem_addr_t  wr_addr_q[$];
    reg_dword_t wr_data_q[$];
    mem_addr_t  exp_addr_q[$];
    reg_dword_t exp_data_q[$];
    logic       exp_invalid;

    logic [31:0] lfsr_state = 32'h65b6;
    int cycle_count = 0;
    int start_cycle;
    int checks = 0;
    int errors = 0;

    `include "makehint_tb_model.svh"

    makehint_top #(
        .DILITHIUM_K (DILITHIUM_K),
        .OMEGA       (OMEGA)
    ) makehint_top_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .makehint_enable (makehint_enable),
        .mem_base_addr   (mem_base_addr),
        .dest_base_addr  (dest_base_addr),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_r          (load_r),
        .load_z          (load_z),
        .invalid_h       (invalid_h),
        .makehint_done   (makehint_done),
        .reg_wren        (reg_wren),
        .reg_wr_addr     (reg_wr_addr),
        .reg_wrdata      (reg_wrdata)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Monitor and timeout
    // ----------------------------------------

    // Mid-cycle sampling, the port has settled by then
    always @(negedge clk) begin
        if (reg_wren) begin
            wr_addr_q.push_back(reg_wr_addr);
            wr_data_q.push_back(reg_wrdata);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic make_coeff(input int kind, output coeff_t r, output logic z);
        int sel;
        z = next_bit();
        if (kind == KIND_BOUNDARY) begin
            // About one coefficient in 32 sits on or next to a band edge
            if (take_bits(5) == 0) begin
                sel = int'(take_bits(3)) % 5;
                case (sel)
                    0: r = coeff_t'(MODEL_GAMMA2);
                    1: r = coeff_t'(MODEL_GAMMA2 + 1);
                    2: begin
                        r = coeff_t'(MODEL_Q - MODEL_GAMMA2);
                        z = 1'b0;
                    end
                    3: begin
                        r = coeff_t'(MODEL_Q - MODEL_GAMMA2);
                        z = 1'b1;
                    end
                    default: r = coeff_t'(MODEL_Q - MODEL_GAMMA2 - 1);
                endcase
            end else begin
                r = coeff_t'(take_bits(17));
            end
        end else if (take_bits((kind == KIND_SPARSE) ? 6 : 4) == 0) begin
            r = coeff_t'(MODEL_GAMMA2 + 1 + int'(take_bits(18)));
        end else if (next_bit()) begin
            // Out of band just below q
            r = coeff_t'(MODEL_Q - 1 - int'(take_bits(17)));
        end else begin
            r = coeff_t'(take_bits(17));
        end
    endtask

    // One memory word per cycle through the load port, starting at word 0
    task automatic fill_memory(input int kind, input mem_addr_t base, input int words);
        coeff4_t word_r;
        zbits_t  word_z;
        coeff_t  r;
        logic    z;
        for (int w = 0; w < words; w++) begin
            for (int i = 0; i < 4; i++) begin
                make_coeff(kind, r, z);
                word_r[i] = r;
                word_z[i] = z;
                coef_r[4*w + i] = r;
                coef_z[4*w + i] = z;
            end
            @(posedge clk);
            #2;
            load_en = 1'b1;
            load_addr = base + mem_addr_t'(w);
            load_r = word_r;
            load_z = word_z;
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
    endtask

    task automatic start_run();
        wr_addr_q.delete();
        wr_data_q.delete();
        @(posedge clk);
        #2;
        makehint_enable = 1'b1;
        start_cycle = cycle_count;
        @(posedge clk);
        #2;
        makehint_enable = 1'b0;
    endtask

    // done rises a fixed number of cycles after the cycle that holds the enable
    task automatic wait_done();
        @(posedge makehint_done);
        checks++;
        if (cycle_count - start_cycle != RUN_CYCLES) begin
            $display("The run took %0d cycles where %0d were expected",
                     cycle_count - start_cycle, RUN_CYCLES);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic check_result(input mem_addr_t dest);
        build_expected(dest);
        compare_writes();
        check_flag("invalid_h", invalid_h, exp_invalid);
    endtask

    task automatic report_test(input int num, input string title, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %0d (%s) ok", num, title);
        end else begin
            $display("Test %0d (%s) has %0d errors", num, title, errors - errors_before);
        end
    endtask

    task automatic run_test(input int num, input string title, input int kind,
                            input mem_addr_t mem_base, input mem_addr_t dest_base);
        int errors_before;
        errors_before = errors;
        fill_memory(kind, mem_base, DILITHIUM_K * 64);
        mem_base_addr = mem_base;
        dest_base_addr = dest_base;
        start_run();
        wait_done();
        check_result(dest_base);
        report_test(num, title, errors_before);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        int errors_before;
        clk = 1'b0;
        reset_n = 1'b0;
        zeroize = 1'b0;
        makehint_enable = 1'b0;
        mem_base_addr = '0;
        dest_base_addr = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_r = '0;
        load_z = '0;
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;

        run_test(1, "sparse hints", KIND_SPARSE, 10'h000, 10'h000);
        run_test(2, "dense hints", KIND_DENSE, 10'h000, 10'h000);
        run_test(3, "boundary values", KIND_BOUNDARY, 10'h000, 10'h000);
        run_test(4, "shifted base addresses", KIND_SPARSE, 10'h1a0, 10'h2c4);

        // Test 5 keeps the bases of test 4 and reloads its first polynomials with dense hints
        errors_before = errors;
        fill_memory(KIND_DENSE, mem_base_addr, ZEROIZE_POLYS * 64);
        start_run();
        // The dense polynomials are fully counted and the next hints have not arrived yet
        repeat (ZEROIZE_POLYS * 66 + 1) @(posedge clk);
        #2;
        check_flag("invalid_h", invalid_h, count_hints(ZEROIZE_POLYS) > OMEGA);
        zeroize = 1'b1;
        @(posedge clk);
        #2;
        zeroize = 1'b0;
        @(negedge clk);
        check_flag("makehint_done", makehint_done, 1'b1);
        check_flag("invalid_h", invalid_h, 1'b0);
        start_run();
        wait_done();
        check_result(dest_base_addr);
        report_test(5, "zeroize in mid-run", errors_before);

        $display("Tests run: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
source/abr_params_pkg.sv
source/makehint_defines_pkg.sv
source/hintgen.sv
source/makehint_sample_buffer.sv
source/makehint_coeff_mem.sv
source/makehint.sv
source/makehint_top.sv
testbench/makehint_tb.sv
